//--- Makefile
# Verilator simulation of the L1 data cache

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run tb_dcache"
	@echo "  clean  remove the obj_dir build folder"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_dcache -f list.f
	@out="$$(./obj_dir/Vtb_dcache)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- common/dcache_pkg.sv
package dcache_pkg;

    // ==============================
    // Line geometry
    // ==============================
    localparam int XLEN             = 32;                 // Processor word
    localparam int BE_W             = XLEN / 8;           // One enable per byte
    localparam int WORDS_PER_LINE   = 4;
    localparam int LINE_W           = XLEN * WORDS_PER_LINE;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_W / 8); // Byte offset inside a line

    typedef logic [XLEN-1:0] word_t;

    // Flat for memory transfers, word view for select and merge
    typedef union packed {
        logic [LINE_W-1:0]          flat;
        word_t [WORDS_PER_LINE-1:0] words;  // Word k at flat[32k +: 32]
    } dcache_line_u;

endpackage

//--- dcache/dcache_ctrl_fsm.sv
module dcache_ctrl_fsm
    import dcache_pkg::*;
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 4,
    localparam int SET_W  = $clog2(N_SETS),
    localparam int WAY_W  = $clog2(N_WAYS),
    localparam int TAG_W  = XLEN - SET_W - LINE_OFFSET_BITS,
    localparam int WORD_W = $clog2(WORDS_PER_LINE)
)
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              p_strobe_i,
    input  logic              p_rw_i,
    input  logic              p_flush_i,
    input  word_t             p_addr_i,
    input  word_t             p_data_i,
    input  logic [BE_W-1:0]   p_byte_enable_i,
    output logic              p_ready_o,
    output logic              busy_flushing_o,
    output word_t             m_addr_o,
    output logic              m_strobe_o,
    output logic              m_rw_o,
    input  logic              m_ready_i,
    input  logic              hit_i,
    input  logic [WAY_W-1:0]  hit_way_i,
    input  logic [WAY_W-1:0]  victim_way_i,
    input  logic              way_dirty_i,   // Of the way on rd_way_o
    input  logic [TAG_W-1:0]  way_tag_i,
    input  logic [SET_W-1:0]  flush_set_i,
    input  logic [WAY_W-1:0]  flush_way_i,
    input  logic              flush_last_i,
    output logic [SET_W-1:0]  sram_set_o,
    output logic [WAY_W-1:0]  rd_way_o,
    output logic [N_WAYS-1:0] way_we_o,
    output logic              mark_valid_o,
    output logic              mark_dirty_o,
    output logic              clear_dirty_o,
    output logic              touch_o,
    output logic              fill_capture_o,
    output logic              fill_sel_o,
    output logic [WORD_W-1:0] req_word_o,
    output logic              req_rw_o,
    output logic [BE_W-1:0]   req_be_o,
    output word_t             req_data_o,
    output logic [TAG_W-1:0]  req_tag_o,
    output logic              flush_start_o,
    output logic              flush_step_o
);

    localparam logic [2:0] ST_IDLE        = 3'd0,
                           ST_LOOKUP      = 3'd1,
                           ST_WB_VICTIM   = 3'd2,
                           ST_FILL        = 3'd3,
                           ST_FILL_DONE   = 3'd4,
                           ST_FLUSH_CHECK = 3'd5,
                           ST_FLUSH_WB    = 3'd6,
                           ST_FLUSH_NEXT  = 3'd7;

    logic [2:0]       state_q;
    logic [2:0]       state_d;
    word_t            req_addr_q;
    logic             req_rw_q;
    word_t            req_data_q;
    logic [BE_W-1:0]  req_be_q;
    logic [SET_W-1:0] req_set;

    // Line base address, offset bits zero
    function automatic word_t line_addr(input logic [TAG_W-1:0] tag,
                                        input logic [SET_W-1:0] idx);
        return {tag, idx, {LINE_OFFSET_BITS{1'b0}}};
    endfunction

    assign req_set    = req_addr_q[LINE_OFFSET_BITS +: SET_W];
    assign req_tag_o  = req_addr_q[XLEN-1 -: TAG_W];
    assign req_word_o = req_addr_q[LINE_OFFSET_BITS-1 -: WORD_W];  // Address bits 3:2
    assign req_rw_o   = req_rw_q;
    assign req_data_o = req_data_q;
    assign req_be_o   = req_be_q;

    assign busy_flushing_o = (state_q == ST_FLUSH_CHECK) || (state_q == ST_FLUSH_WB) ||
                             (state_q == ST_FLUSH_NEXT);

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    // Request latch, only taken while idle
    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_IDLE && p_strobe_i)
        begin
            req_addr_q <= p_addr_i;
            req_rw_q   <= p_rw_i;
            req_data_q <= p_data_i;
            req_be_q   <= p_byte_enable_i;
        end
    end

    // ==============================
    // Next state and strobes
    // ==============================
    always_comb
    begin
        state_d        = state_q;
        p_ready_o      = 1'b0;
        m_strobe_o     = 1'b0;
        m_rw_o         = 1'b0;
        m_addr_o       = '0;
        way_we_o       = '0;
        mark_valid_o   = 1'b0;
        mark_dirty_o   = 1'b0;
        clear_dirty_o  = 1'b0;
        touch_o        = 1'b0;
        fill_capture_o = 1'b0;
        fill_sel_o     = 1'b0;
        flush_start_o  = 1'b0;
        flush_step_o   = 1'b0;
        sram_set_o     = busy_flushing_o ? flush_set_i : req_set;
        rd_way_o       = busy_flushing_o ? flush_way_i : victim_way_i;

        case (state_q)
            ST_IDLE:
            begin
                sram_set_o = p_addr_i[LINE_OFFSET_BITS +: SET_W];  // Sync read starts now
                if (p_strobe_i)
                    state_d = ST_LOOKUP;
                else if (p_flush_i)
                begin
                    flush_start_o = 1'b1;
                    state_d       = ST_FLUSH_CHECK;
                end
            end
            ST_LOOKUP:
            begin
                if (hit_i)
                begin
                    rd_way_o     = hit_way_i;
                    p_ready_o    = 1'b1;
                    touch_o      = 1'b1;
                    way_we_o     = req_rw_q ? N_WAYS'(1) << hit_way_i : '0;  // Store hit
                    mark_dirty_o = req_rw_q;
                    state_d      = ST_IDLE;
                end
                else
                    state_d = way_dirty_i ? ST_WB_VICTIM : ST_FILL;
            end
            ST_WB_VICTIM:
            begin
                m_strobe_o = 1'b1;
                m_rw_o     = 1'b1;
                m_addr_o   = line_addr(way_tag_i, req_set);  // Victim's own address
                if (m_ready_i)
                    state_d = ST_FILL;
            end
            ST_FILL:
            begin
                m_strobe_o     = 1'b1;
                m_addr_o       = line_addr(req_tag_o, req_set);
                fill_capture_o = m_ready_i;
                if (m_ready_i)
                    state_d = ST_FILL_DONE;
            end
            ST_FILL_DONE:
            begin
                fill_sel_o    = 1'b1;
                way_we_o      = N_WAYS'(1) << victim_way_i;
                mark_valid_o  = 1'b1;
                mark_dirty_o  = req_rw_q;   // Write miss leaves the line dirty
                clear_dirty_o = !req_rw_q;
                touch_o       = 1'b1;
                p_ready_o     = 1'b1;
                state_d       = ST_IDLE;
            end
            ST_FLUSH_CHECK:
            begin
                if (way_dirty_i)
                    state_d = ST_FLUSH_WB;
                else if (flush_last_i)
                begin
                    p_ready_o = 1'b1;
                    state_d   = ST_IDLE;
                end
                else
                    flush_step_o = 1'b1;  // Clean pair, one cycle only
            end
            ST_FLUSH_WB:
            begin
                m_strobe_o = 1'b1;
                m_rw_o     = 1'b1;
                m_addr_o   = line_addr(way_tag_i, flush_set_i);
                if (m_ready_i)
                    state_d = ST_FLUSH_NEXT;
            end
            default:  // ST_FLUSH_NEXT
            begin
                clear_dirty_o = 1'b1;  // Line now matches memory
                if (flush_last_i)
                begin
                    p_ready_o = 1'b1;
                    state_d   = ST_IDLE;
                end
                else
                begin
                    flush_step_o = 1'b1;
                    state_d      = ST_FLUSH_CHECK;
                end
            end
        endcase
    end

endmodule

//--- dcache/dcache_data_store.sv
module dcache_data_store
    import dcache_pkg::*;
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 4,
    localparam int SET_W  = $clog2(N_SETS),
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic              clk_i,
    input  logic [SET_W-1:0]  set_i,
    input  logic [N_WAYS-1:0] way_we_i,
    input  dcache_line_u      line_i,
    input  logic [WAY_W-1:0]  rd_way_i,
    output dcache_line_u      line_o
);

    dcache_line_u line_mem [N_WAYS][N_SETS];
    dcache_line_u line_q   [N_WAYS];  // Every way read each cycle

    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (way_we_i[w])
                line_mem[w][set_i] <= line_i;
            line_q[w] <= line_mem[w][set_i];  // Old data on a same-cycle write
        end
    end

    assign line_o = line_q[rd_way_i];  // Way picked after the read

endmodule

//--- dcache/dcache_flush_counter.sv
module dcache_flush_counter
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 4,
    localparam int SET_W  = $clog2(N_SETS),
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             start_i,  // Back to set 0, way 0
    input  logic             step_i,
    output logic [SET_W-1:0] set_o,
    output logic [WAY_W-1:0] way_o,
    output logic             last_o
);

    logic set_wrap;

    assign set_wrap = (set_o == SET_W'(N_SETS - 1));
    assign last_o   = set_wrap && (way_o == WAY_W'(N_WAYS - 1));

    // Sets run fastest, then the way moves on
    always_ff @(posedge clk_i)
    begin
        if (rst_i || start_i)
        begin
            set_o <= '0;
            way_o <= '0;
        end
        else if (step_i)
        begin
            set_o <= set_wrap ? '0 : set_o + 1'b1;
            if (set_wrap)
                way_o <= way_o + 1'b1;
        end
    end

endmodule

//--- dcache/dcache_line_merge.sv
module dcache_line_merge
    import dcache_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              fill_capture_i,
    input  dcache_line_u                      m_line_i,
    input  dcache_line_u                      cache_line_i,
    input  logic                              fill_sel_i,    // Use the fill, not the hit line
    input  logic [$clog2(WORDS_PER_LINE)-1:0] word_i,
    input  logic                              rw_i,
    input  logic [BE_W-1:0]                   be_i,
    input  word_t                             data_i,
    output dcache_line_u                      line_o,
    output word_t                             rd_word_o
);

    dcache_line_u fill_q;
    dcache_line_u base_line;

    // Fill line held until the write cycle
    always_ff @(posedge clk_i)
    begin
        if (fill_capture_i)
            fill_q <= m_line_i;
    end

    // ==============================
    // Word select and byte merge
    // ==============================
    always_comb
    begin
        base_line = fill_sel_i ? fill_q : cache_line_i;
        rd_word_o = base_line.words[word_i];  // Value before the store
        line_o    = base_line;
        if (rw_i)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (be_i[b])
                    line_o.words[word_i][8*b +: 8] = data_i[8*b +: 8];
            end
        end
    end

endmodule

//--- dcache/dcache_plru.sv
module dcache_plru
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 4,
    localparam int SET_W  = $clog2(N_SETS),
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [SET_W-1:0] set_i,
    input  logic             touch_i,
    input  logic [WAY_W-1:0] touch_way_i,
    output logic [WAY_W-1:0] victim_way_o
);

    // Heap order, node n has children 2n+1 and 2n+2
    // Bit set means the victim lies on the right
    logic [N_WAYS-2:0] plru_q [N_SETS];
    logic [N_WAYS-2:0] cur_bits;
    logic [N_WAYS-2:0] touched;
    int                vnode;
    int                tnode;

    assign cur_bits = plru_q[set_i];

    always_comb
    begin
        vnode   = 0;
        tnode   = 0;
        touched = cur_bits;
        for (int l = 0; l < WAY_W; l++)
        begin
            victim_way_o[WAY_W-1-l] = cur_bits[vnode];  // Follow the bits down
            vnode = 2 * vnode + 1 + int'(cur_bits[vnode]);
            touched[tnode] = !touch_way_i[WAY_W-1-l];   // Point away from the used way
            tnode = 2 * tnode + 1 + int'(touch_way_i[WAY_W-1-l]);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                plru_q[s] <= '0;
        end
        else if (touch_i)
            plru_q[set_i] <= touched;
    end

endmodule

//--- dcache/dcache_tag_store.sv
module dcache_tag_store
    import dcache_pkg::*;
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 4,
    localparam int SET_W  = $clog2(N_SETS),
    localparam int WAY_W  = $clog2(N_WAYS),
    localparam int TAG_W  = XLEN - SET_W - LINE_OFFSET_BITS
)
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [SET_W-1:0]  set_i,
    input  logic [TAG_W-1:0]  tag_i,         // Request tag, compare and write
    input  logic [N_WAYS-1:0] way_we_i,
    input  logic [WAY_W-1:0]  sel_way_i,     // Victim, hit or flush way
    input  logic              mark_valid_i,
    input  logic              mark_dirty_i,
    input  logic              clear_dirty_i,
    input  logic              flush_i,
    output logic              hit_o,
    output logic [WAY_W-1:0]  hit_way_o,
    output logic              way_dirty_o,
    output logic [TAG_W-1:0]  way_tag_o
);

    logic [TAG_W-1:0]  tag_mem [N_WAYS][N_SETS];
    logic [TAG_W-1:0]  tag_q   [N_WAYS];
    logic [N_WAYS-1:0] valid_q [N_SETS];
    logic [N_WAYS-1:0] dirty_q [N_SETS];
    logic [N_WAYS-1:0] way_hit;

    // Tag arrays, read one cycle after the set
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (way_we_i[w])
                tag_mem[w][set_i] <= tag_i;
            tag_q[w] <= tag_mem[w][set_i];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else
        begin
            if (mark_valid_i)
                valid_q[set_i][sel_way_i] <= 1'b1;
            if (mark_dirty_i)
                dirty_q[set_i][sel_way_i] <= 1'b1;
            else if (clear_dirty_i)
                dirty_q[set_i][sel_way_i] <= 1'b0;
        end
    end

    // ==============================
    // Compare and encode
    // ==============================
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            way_hit[w] = valid_q[set_i][w] && (tag_q[w] == tag_i);
            if (way_hit[w])
                hit_way_o = WAY_W'(w);
        end
    end

    assign hit_o       = (|way_hit) && !flush_i;  // Request tag is stale while flushing
    assign way_dirty_o = dirty_q[set_i][sel_way_i];
    assign way_tag_o   = tag_q[sel_way_i];

endmodule

//--- dcache/dcache_top.sv
module dcache_top
    import dcache_pkg::*;
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 4,
    localparam int SET_W  = $clog2(N_SETS),
    localparam int WAY_W  = $clog2(N_WAYS),
    localparam int TAG_W  = XLEN - SET_W - LINE_OFFSET_BITS,
    localparam int WORD_W = $clog2(WORDS_PER_LINE)
)
(
    input  logic            clk_i,
    input  logic            rst_i,
    // Processor side
    input  logic            p_strobe_i,
    input  logic            p_rw_i,           // 1 for store
    input  logic            p_flush_i,
    input  logic [BE_W-1:0] p_byte_enable_i,
    input  word_t           p_addr_i,
    input  word_t           p_data_i,
    output word_t           p_data_o,
    output logic            p_ready_o,
    output logic            busy_flushing_o,
    // Memory side, one line per transfer
    output word_t           m_addr_o,
    output dcache_line_u    m_data_o,
    input  dcache_line_u    m_data_i,
    output logic            m_strobe_o,
    output logic            m_rw_o,
    input  logic            m_ready_i
);

    logic [SET_W-1:0]  sram_set;
    logic [SET_W-1:0]  flush_set;
    logic [WAY_W-1:0]  rd_way;
    logic [WAY_W-1:0]  hit_way;
    logic [WAY_W-1:0]  victim_way;
    logic [WAY_W-1:0]  flush_way;
    logic [N_WAYS-1:0] way_we;
    logic [TAG_W-1:0]  way_tag;
    logic [TAG_W-1:0]  req_tag;
    logic [WORD_W-1:0] req_word;
    logic [BE_W-1:0]   req_be;
    word_t             req_data;
    logic              req_rw;
    logic              hit;
    logic              way_dirty;
    logic              flush_last;
    logic              flush_start;
    logic              flush_step;
    logic              mark_valid;
    logic              mark_dirty;
    logic              clear_dirty;
    logic              touch;
    logic              fill_capture;
    logic              fill_sel;
    dcache_line_u      cache_line;   // Selected way, also the write-back data
    dcache_line_u      merged_line;

    assign m_data_o = cache_line;

    dcache_ctrl_fsm #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i),
        .p_strobe_i(p_strobe_i), .p_rw_i(p_rw_i), .p_flush_i(p_flush_i),
        .p_addr_i(p_addr_i), .p_data_i(p_data_i), .p_byte_enable_i(p_byte_enable_i),
        .p_ready_o(p_ready_o), .busy_flushing_o(busy_flushing_o),
        .m_addr_o(m_addr_o), .m_strobe_o(m_strobe_o), .m_rw_o(m_rw_o),
        .m_ready_i(m_ready_i),
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .way_dirty_i(way_dirty), .way_tag_i(way_tag),
        .flush_set_i(flush_set), .flush_way_i(flush_way), .flush_last_i(flush_last),
        .sram_set_o(sram_set), .rd_way_o(rd_way), .way_we_o(way_we),
        .mark_valid_o(mark_valid), .mark_dirty_o(mark_dirty), .clear_dirty_o(clear_dirty),
        .touch_o(touch), .fill_capture_o(fill_capture), .fill_sel_o(fill_sel),
        .req_word_o(req_word), .req_rw_o(req_rw), .req_be_o(req_be),
        .req_data_o(req_data), .req_tag_o(req_tag),
        .flush_start_o(flush_start), .flush_step_o(flush_step)
    );

    dcache_flush_counter #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_flush_cnt (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(flush_start), .step_i(flush_step),
        .set_o(flush_set), .way_o(flush_way), .last_o(flush_last)
    );

    dcache_tag_store #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_tags (
        .clk_i(clk_i), .rst_i(rst_i), .set_i(sram_set), .tag_i(req_tag),
        .way_we_i(way_we), .sel_way_i(rd_way),
        .mark_valid_i(mark_valid), .mark_dirty_i(mark_dirty),
        .clear_dirty_i(clear_dirty), .flush_i(busy_flushing_o),
        .hit_o(hit), .hit_way_o(hit_way), .way_dirty_o(way_dirty), .way_tag_o(way_tag)
    );

    dcache_data_store #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_data (
        .clk_i(clk_i), .set_i(sram_set), .way_we_i(way_we), .line_i(merged_line),
        .rd_way_i(rd_way), .line_o(cache_line)
    );

    dcache_plru #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_plru (
        .clk_i(clk_i), .rst_i(rst_i), .set_i(sram_set), .touch_i(touch),
        .touch_way_i(rd_way), .victim_way_o(victim_way)
    );

    dcache_line_merge u_merge (
        .clk_i(clk_i), .fill_capture_i(fill_capture), .m_line_i(m_data_i),
        .cache_line_i(cache_line), .fill_sel_i(fill_sel), .word_i(req_word),
        .rw_i(req_rw), .be_i(req_be), .data_i(req_data),
        .line_o(merged_line), .rd_word_o(p_data_o)
    );

endmodule

//--- list.f
common/dcache_pkg.sv
dcache/dcache_flush_counter.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
dcache/dcache_plru.sv
dcache/dcache_line_merge.sv
dcache/dcache_ctrl_fsm.sv
dcache/dcache_top.sv
verification/tb_mem_model.sv
verification/tb_dcache.sv

//--- verification/dcache_golden.txt
# op addr     wdata    be expected (read data, or memory writes for F)
# Memory word = byte address ^ A5A50000, 4 ways x 4 sets, set = addr[5:4]
R 00000004 00000000 0 A5A50004
R 00000008 00000000 0 A5A50008
W 00000004 11223344 5 00000000
R 00000004 00000000 0 A5220044
R 00000040 00000000 0 A5A50040
R 00000080 00000000 0 A5A50080
R 000000C0 00000000 0 A5A500C0
R 00000100 00000000 0 A5A50100
R 00000004 00000000 0 A5220044
R 00000000 00000000 0 A5A50000
W 0000001C DEADBEEF F 00000000
R 0000001C 00000000 0 DEADBEEF
R 00000018 00000000 0 A5A50018
W 000000A8 55667788 8 00000000
R 000000A8 00000000 0 55A500A8
F 00000000 00000000 0 00000002
R 0000001C 00000000 0 DEADBEEF
F 00000000 00000000 0 00000000
R 000000AC 00000000 0 A5A500AC

//--- verification/tb_dcache.sv
module tb_dcache
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int    N_WAYS      = 4;
    localparam int    N_SETS      = 4;
    localparam int    RNG_SEED    = 91930;
    localparam word_t MEM_PATTERN = 32'hA5A5_0000;  // Memory word = byte address ^ pattern

    logic            clk = 1'b0;
    logic            rst;
    logic            p_strobe;
    logic            p_rw;
    logic            p_flush;
    logic [BE_W-1:0] p_be;
    word_t           p_addr;
    word_t           p_wdata;
    word_t           p_rdata;
    logic            p_ready;
    logic            busy_flushing;
    word_t           m_addr;
    dcache_line_u    m_wdata;
    dcache_line_u    m_rdata;
    logic            m_strobe;
    logic            m_rw;
    logic            m_ready;
    int              wr_cnt;
    int              rd_cnt;

    // One queue entry per operation line of the file
    logic [7:0]      op_q   [$];
    word_t           addr_q [$];
    word_t           data_q [$];
    logic [BE_W-1:0] be_q   [$];
    word_t           exp_q  [$];

    int           n_ops       = 0;
    int           limit       = 0;
    int           cycle_count = 0;
    int           errors      = 0;
    int           checks      = 0;
    word_t        prev_line   = '0;
    logic         prev_valid  = 1'b0;
    logic         waiting     = 1'b0;   // Memory request still open
    word_t        held_addr   = '0;
    logic         held_rw     = 1'b0;
    dcache_line_u held_data   = '0;

    always #10 clk = ~clk;

    dcache_top #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_dut (
        .clk_i(clk), .rst_i(rst),
        .p_strobe_i(p_strobe), .p_rw_i(p_rw), .p_flush_i(p_flush),
        .p_byte_enable_i(p_be), .p_addr_i(p_addr), .p_data_i(p_wdata),
        .p_data_o(p_rdata), .p_ready_o(p_ready), .busy_flushing_o(busy_flushing),
        .m_addr_o(m_addr), .m_data_o(m_wdata), .m_data_i(m_rdata),
        .m_strobe_o(m_strobe), .m_rw_o(m_rw), .m_ready_i(m_ready)
    );

    tb_mem_model #(
        .PATTERN(MEM_PATTERN), .LAT_MIN(1), .LAT_MAX(4), .SEED(RNG_SEED)
    ) u_mem (
        .clk_i(clk), .rst_i(rst), .m_strobe_i(m_strobe), .m_rw_i(m_rw),
        .m_addr_i(m_addr), .m_data_i(m_wdata), .m_data_o(m_rdata),
        .m_ready_o(m_ready), .write_count_o(wr_cnt), .read_count_o(rd_cnt)
    );

    // Op, address, store data, byte enables and expected value per line
    task automatic read_op_file();
        int          fd;
        int          n;
        string       line;
        logic [15:0] op;
        word_t       a;
        word_t       d;
        word_t       e;
        logic [31:0] be;
        fd = $fopen("verification/dcache_golden.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#")   // Skip blanks and column notes
                begin
                    n = $sscanf(line, "%s %h %h %h %h", op, a, d, be, e);
                    if (n == 5)
                    begin
                        op_q.push_back(op[7:0]);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        be_q.push_back(be[BE_W-1:0]);
                        exp_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        n_ops = op_q.size();
    endtask

    // Single load or store through the hit or miss path
    task automatic access_and_check(input int i);
        int    lat;
        int    txn0;
        word_t line;
        logic  same_line;
        line      = addr_q[i] & ~word_t'(LINE_W / 8 - 1);
        same_line = prev_valid && (line == prev_line);  // Line just used must still hit
        txn0      = wr_cnt + rd_cnt;
        @(posedge clk);
        p_strobe <= 1'b1;
        p_rw     <= (op_q[i] == "W");
        p_addr   <= addr_q[i];
        p_wdata  <= data_q[i];
        p_be     <= be_q[i];
        @(posedge clk);
        p_strobe <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!p_ready)
        begin
            lat++;
            @(negedge clk);
        end
        checks++;
        if (op_q[i] == "R" && p_rdata !== exp_q[i])
        begin
            errors++;
            $display("Error: p_data_o at %h got %h expected %h", addr_q[i], p_rdata, exp_q[i]);
        end
        if (wr_cnt + rd_cnt == txn0 && lat != 1)
        begin
            errors++;
            $display("Access to %h took %0d cycles with no memory traffic", addr_q[i], lat);
        end
        if (same_line && wr_cnt + rd_cnt != txn0)
        begin
            errors++;
            $display("Line %h missed right after it was used", line);
        end
        prev_line  = line;
        prev_valid = 1'b1;
    endtask

    // Expected column holds the write-back count of the flush
    task automatic flush_and_check(input int i);
        int   w0;
        logic busy_lost;
        w0        = wr_cnt;
        busy_lost = 1'b0;
        @(posedge clk);
        p_flush <= 1'b1;
        @(posedge clk);
        p_flush <= 1'b0;
        @(negedge clk);
        while (!p_ready)
        begin
            busy_lost |= !busy_flushing;
            @(negedge clk);
        end
        busy_lost |= !busy_flushing;   // Still high in the ready cycle
        checks++;
        if (busy_lost)
        begin
            errors++;
            $display("busy_flushing_o was low during the flush");
        end
        @(negedge clk);
        if (busy_flushing)
        begin
            errors++;
            $display("busy_flushing_o still high after the flush finished");
        end
        if (wr_cnt - w0 != int'(exp_q[i]))
        begin
            errors++;
            $display("Error: memory write count got %h expected %h", wr_cnt - w0, exp_q[i]);
        end
    endtask

    task automatic replay_ops();
        limit = n_ops * (2 * N_WAYS * N_SETS + 20);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (p_ready || m_strobe || m_rw || busy_flushing)
        begin
            errors++;
            $display("Outputs not idle after reset");
        end
        for (int i = 0; i < n_ops; i++)
        begin
            if (op_q[i] == "F")
                flush_and_check(i);
            else
                access_and_check(i);
        end
    endtask

    // ==============================
    // Memory port monitor
    // ==============================
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (m_strobe && m_addr[LINE_OFFSET_BITS-1:0] != '0)
            begin
                errors++;
                $display("Error: m_addr_o got %h expected a line-aligned address", m_addr);
            end
            if (waiting && (!m_strobe || m_addr !== held_addr || m_rw !== held_rw ||
                            (m_rw && m_wdata !== held_data)))
            begin
                errors++;
                $display("Memory request changed before m_ready_i");
            end
            waiting   = m_strobe && !m_ready;
            held_addr = m_addr;
            held_rw   = m_rw;
            held_data = m_wdata;
        end
    end

    // Cycle limit from the operation count
    initial
    begin
        @(posedge clk);
        while (cycle_count < limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles", cycle_count);
        $display("%0d checks, %0d errors", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_flush  = 1'b0;
        p_be     = '0;
        p_addr   = '0;
        p_wdata  = '0;
        read_op_file();
        if (n_ops == 0)
            $display("Golden file missing or empty, nothing was run");
        else
            replay_ops();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && n_ops > 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verification/tb_mem_model.sv
module tb_mem_model
    import dcache_pkg::*;
#(
    parameter word_t PATTERN = 32'hA5A5_0000,
    parameter int    LAT_MIN = 1,
    parameter int    LAT_MAX = 4,
    parameter int    SEED    = 91930
)
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         m_strobe_i,
    input  logic         m_rw_i,
    input  word_t        m_addr_i,
    input  dcache_line_u m_data_i,    // Write-back line from the cache
    output dcache_line_u m_data_o,
    output logic         m_ready_o,
    output int           write_count_o,
    output int           read_count_o
);
    timeunit 1ns;
    timeprecision 1ns;

    dcache_line_u lines [word_t];     // Only lines written back are stored
    dcache_line_u rd_line   = '0;
    logic         ready     = 1'b0;
    logic         busy      = 1'b0;
    int           wait_left = 0;
    int           writes    = 0;
    int           reads     = 0;

    assign m_data_o      = rd_line;
    assign m_ready_o     = ready;
    assign write_count_o = writes;
    assign read_count_o  = reads;

    // Stored line or the address pattern when never written
    function automatic dcache_line_u line_at(input word_t base);
        dcache_line_u l;
        if (lines.exists(base))
            return lines[base];
        for (int k = 0; k < WORDS_PER_LINE; k++)
            l.words[k] = (base + word_t'(4 * k)) ^ PATTERN;
        return l;
    endfunction

    // Seeded once, then one step per rising edge
    initial
    begin
        void'($urandom(SEED));
        forever
        begin
            @(posedge clk_i);
            if (rst_i)
            begin
                ready     <= 1'b0;
                busy      <= 1'b0;
                wait_left <= 0;
            end
            else if (ready)
            begin
                ready <= 1'b0;   // Cache leaves its wait state on this edge
                busy  <= 1'b0;
            end
            else if (m_strobe_i)
            begin
                if (!busy)
                begin
                    busy      <= 1'b1;
                    wait_left <= int'($urandom_range(LAT_MAX, LAT_MIN)) - 1;
                end
                else if (wait_left > 0)
                    wait_left <= wait_left - 1;
                else
                begin
                    ready <= 1'b1;
                    if (m_rw_i)
                    begin
                        lines[m_addr_i] = m_data_i;
                        writes <= writes + 1;
                    end
                    else
                    begin
                        rd_line <= line_at(m_addr_i);
                        reads   <= reads + 1;
                    end
                end
            end
        end
    end

endmodule
